// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fc_lcc_svc
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG); grep -q "^Testbench passed$$" $(LOG)

check:
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/fc_lcc_svc_pkg.sv
package fc_lcc_svc_pkg;

  // --------------------------------------------------
  // OTP geometry and partition map
  // --------------------------------------------------
  localparam int OTP_WORD_W = 16;
  localparam int OTP_ADDR_W = 6;
  localparam int NUM_PART   = 4;

  // First word of each partition
  localparam logic [OTP_ADDR_W-1:0] PART_OFFSET [NUM_PART] = '{6'd0, 6'd12, 6'd24, 6'd40};
  // Digest word of each partition, nonzero once the partition is locked
  localparam logic [OTP_ADDR_W-1:0] PART_DIGEST [NUM_PART] = '{6'd10, 6'd22, 6'd38, 6'd62};

  // --------------------------------------------------
  // Service command encoding
  // --------------------------------------------------
  // Upper nibble selects the group that owns the command
  localparam logic [3:0] GRP_OVERRIDE  = 4'h0;
  localparam logic [3:0] GRP_CLOCK     = 4'h1;
  localparam logic [3:0] GRP_RST_FAULT = 4'h2;

  localparam logic [7:0] CMD_ZEROIZE_ON          = 8'h00;
  localparam logic [7:0] CMD_ZEROIZE_OFF         = 8'h01;
  localparam logic [7:0] CMD_ZEROIZE_RELEASE     = 8'h02;
  localparam logic [7:0] CMD_TRIGGER_ESCALATION  = 8'h03;
  localparam logic [7:0] CMD_DISABLE_SVA         = 8'h04;
  localparam logic [7:0] CMD_ENABLE_SVA          = 8'h05;
  localparam logic [7:0] CMD_EXT_CLK_160         = 8'h10;
  localparam logic [7:0] CMD_EXT_CLK_400         = 8'h11;
  localparam logic [7:0] CMD_EXT_CLK_500         = 8'h12;
  localparam logic [7:0] CMD_EXT_CLK_1000        = 8'h13;
  localparam logic [7:0] CMD_FC_LCC_RESET        = 8'h20;
  localparam logic [7:0] CMD_CORRECTABLE_FAULT   = 8'h21;
  localparam logic [7:0] CMD_UNCORRECTABLE_FAULT = 8'h22;

  // The same byte seen whole or as group and op nibbles
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [3:0] group;
      logic [3:0] op;
    } f;
  } svc_cmd_u;

  typedef enum logic [1:0] {
    CLK_160  = 2'd0,
    CLK_400  = 2'd1,
    CLK_500  = 2'd2,
    CLK_1000 = 2'd3
  } ext_clk_sel_e;

  typedef enum logic {
    FAULT_CORRECTABLE   = 1'b0,
    FAULT_UNCORRECTABLE = 1'b1
  } fault_kind_e;

endpackage

// File: design/fc_lcc_svc_top.sv
module fc_lcc_svc_top #(
  parameter int RESET_CYCLES = 10
) (
  input  logic                                  clk,
  input  logic                                  cptra_rst_b,
  input  logic                                  tb_service_cmd_valid_i,
  input  fc_lcc_svc_pkg::svc_cmd_u              tb_service_cmd_i,
  input  logic                                  fips_zeroize_i,
  input  logic                                  clk_byp_ack_i,
  input  logic                                  otp_wr_en_i,
  input  logic [fc_lcc_svc_pkg::OTP_ADDR_W-1:0] otp_addr_i,
  input  logic [fc_lcc_svc_pkg::OTP_WORD_W-1:0] otp_wdata_i,
  input  logic [fc_lcc_svc_pkg::OTP_ADDR_W-1:0] otp_rd_addr_i,
  output logic                                  zeroize_o,
  output logic                                  escalate_o,
  output logic                                  sva_disable_o,
  output logic                                  clk_byp_req_o,
  output logic                                  clk_switch_o,
  output fc_lcc_svc_pkg::ext_clk_sel_e          clk_sel_o,
  output logic                                  fc_lcc_rst_b_o,
  output logic [fc_lcc_svc_pkg::OTP_WORD_W-1:0] otp_rdata_o
);

  // Command strobes from the decoder
  logic                         clk_cmd_stb;
  fc_lcc_svc_pkg::ext_clk_sel_e clk_cmd_sel;
  logic                         rst_cmd_stb;
  logic                         fault_cmd_stb;
  fc_lcc_svc_pkg::fault_kind_e  fault_kind;

  // OTP array to fault injector
  logic [fc_lcc_svc_pkg::OTP_WORD_W-1:0] raw_rdata;
  logic [fc_lcc_svc_pkg::NUM_PART-1:0][fc_lcc_svc_pkg::OTP_WORD_W-1:0] part_word;
  logic [fc_lcc_svc_pkg::NUM_PART-1:0] part_locked;

  svc_override_ctrl i_override_ctrl (
    .clk                    (clk),
    .cptra_rst_b            (cptra_rst_b),
    .tb_service_cmd_valid_i (tb_service_cmd_valid_i),
    .tb_service_cmd_i       (tb_service_cmd_i),
    .fips_zeroize_i         (fips_zeroize_i),
    .zeroize_o              (zeroize_o),
    .escalate_o             (escalate_o),
    .sva_disable_o          (sva_disable_o),
    .clk_cmd_stb_o          (clk_cmd_stb),
    .clk_cmd_sel_o          (clk_cmd_sel),
    .rst_cmd_stb_o          (rst_cmd_stb),
    .fault_cmd_stb_o        (fault_cmd_stb),
    .fault_kind_o           (fault_kind)
  );

  svc_clk_switch_fsm i_clk_switch_fsm (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .clk_cmd_stb_i (clk_cmd_stb),
    .clk_cmd_sel_i (clk_cmd_sel),
    .clk_byp_ack_i (clk_byp_ack_i),
    .clk_byp_req_o (clk_byp_req_o),
    .clk_switch_o  (clk_switch_o),
    .clk_sel_o     (clk_sel_o)
  );

  svc_reset_timer #(
    .RESET_CYCLES (RESET_CYCLES)
  ) i_reset_timer (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .rst_cmd_stb_i  (rst_cmd_stb),
    .fc_lcc_rst_b_o (fc_lcc_rst_b_o)
  );

  otp_mem i_otp_mem (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .wr_en_i       (otp_wr_en_i),
    .wr_addr_i     (otp_addr_i),
    .wr_data_i     (otp_wdata_i),
    .rd_addr_i     (otp_rd_addr_i),
    .rd_data_o     (raw_rdata),
    .part_word_o   (part_word),
    .part_locked_o (part_locked)
  );

  otp_fault_inject i_otp_fault_inject (
    .clk             (clk),
    .cptra_rst_b     (cptra_rst_b),
    .fault_cmd_stb_i (fault_cmd_stb),
    .fault_kind_i    (fault_kind),
    .part_word_i     (part_word),
    .part_locked_i   (part_locked),
    .rd_addr_i       (otp_rd_addr_i),
    .raw_rdata_i     (raw_rdata),
    .rdata_o         (otp_rdata_o)
  );

endmodule

// File: design/otp_fault_inject.sv
module otp_fault_inject (
  input  logic                                  clk,
  input  logic                                  cptra_rst_b,
  input  logic                                  fault_cmd_stb_i,
  input  fc_lcc_svc_pkg::fault_kind_e           fault_kind_i,
  input  logic [fc_lcc_svc_pkg::NUM_PART-1:0][fc_lcc_svc_pkg::OTP_WORD_W-1:0] part_word_i,
  input  logic [fc_lcc_svc_pkg::NUM_PART-1:0]   part_locked_i,
  input  logic [fc_lcc_svc_pkg::OTP_ADDR_W-1:0] rd_addr_i,
  input  logic [fc_lcc_svc_pkg::OTP_WORD_W-1:0] raw_rdata_i,
  output logic [fc_lcc_svc_pkg::OTP_WORD_W-1:0] rdata_o
);

  localparam int WW = fc_lcc_svc_pkg::OTP_WORD_W;
  localparam int NP = fc_lcc_svc_pkg::NUM_PART;

  logic                                  active_q;
  logic                                  capture;
  logic [NP-1:0][WW-1:0]                 flip_mask;
  logic [NP-1:0][WW-1:0]                 faulted_q;
  logic [fc_lcc_svc_pkg::OTP_ADDR_W-1:0] rd_addr_q;

  // Only the first fault command is taken
  assign capture = fault_cmd_stb_i && !active_q;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      active_q <= 1'b0;
    end else if (capture) begin
      active_q <= 1'b1;
    end
  end

  // --------------------------------------------------
  // Faulted word per partition
  // --------------------------------------------------
  for (genvar p = 0; p < NP; p++) begin : g_mask
    // Unlocked partitions are left intact
    assign flip_mask[p] = !part_locked_i[p] ? '0 :
                          (fault_kind_i == fc_lcc_svc_pkg::FAULT_UNCORRECTABLE) ? '1 :
                          WW'(1);
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      faulted_q <= part_word_i ^ flip_mask;
    end
  end

  // Address tracks the registered read data of the array
  always_ff @(posedge clk) begin
    rd_addr_q <= rd_addr_i;
  end

  // --------------------------------------------------
  // Read path overlay
  // --------------------------------------------------
  always_comb begin
    rdata_o = raw_rdata_i;
    if (active_q) begin
      for (int p = 0; p < NP; p++) begin
        if (rd_addr_q == fc_lcc_svc_pkg::PART_OFFSET[p]) begin
          rdata_o = faulted_q[p];
        end
      end
    end
  end

  a_active_sticky: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    active_q |=> active_q);

endmodule

// File: design/otp_mem.sv
module otp_mem (
  input  logic                                clk,
  input  logic                                cptra_rst_b,
  input  logic                                wr_en_i,
  input  logic [fc_lcc_svc_pkg::OTP_ADDR_W-1:0] wr_addr_i,
  input  logic [fc_lcc_svc_pkg::OTP_WORD_W-1:0] wr_data_i,
  input  logic [fc_lcc_svc_pkg::OTP_ADDR_W-1:0] rd_addr_i,
  output logic [fc_lcc_svc_pkg::OTP_WORD_W-1:0] rd_data_o,
  output logic [fc_lcc_svc_pkg::NUM_PART-1:0][fc_lcc_svc_pkg::OTP_WORD_W-1:0] part_word_o,
  output logic [fc_lcc_svc_pkg::NUM_PART-1:0] part_locked_o
);

  localparam int DEPTH = 1 << fc_lcc_svc_pkg::OTP_ADDR_W;

  logic [fc_lcc_svc_pkg::OTP_WORD_W-1:0] mem [DEPTH];
  logic [fc_lcc_svc_pkg::OTP_WORD_W-1:0] rd_data_q;

  // --------------------------------------------------
  // Preload write port
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // Registered read, one cycle of latency
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rd_data_q <= '0;
    end else begin
      rd_data_q <= mem[rd_addr_i];
    end
  end

  assign rd_data_o = rd_data_q;

  // --------------------------------------------------
  // Partition views for the fault injector
  // --------------------------------------------------
  for (genvar p = 0; p < fc_lcc_svc_pkg::NUM_PART; p++) begin : g_part
    assign part_word_o[p] = mem[fc_lcc_svc_pkg::PART_OFFSET[p]];
    // A written digest marks the partition as locked
    assign part_locked_o[p] = |mem[fc_lcc_svc_pkg::PART_DIGEST[p]];
  end

endmodule

// File: design/svc_clk_switch_fsm.sv
module svc_clk_switch_fsm (
  input  logic                         clk,
  input  logic                         cptra_rst_b,
  input  logic                         clk_cmd_stb_i,
  input  fc_lcc_svc_pkg::ext_clk_sel_e clk_cmd_sel_i,
  input  logic                         clk_byp_ack_i,
  output logic                         clk_byp_req_o,
  output logic                         clk_switch_o,
  output fc_lcc_svc_pkg::ext_clk_sel_e clk_sel_o
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_REQ    = 2'd1;
  localparam logic [1:0] ST_SWITCH = 2'd2;

  logic [1:0]                   state_q;
  fc_lcc_svc_pkg::ext_clk_sel_e pend_sel_q;
  fc_lcc_svc_pkg::ext_clk_sel_e clk_sel_q;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      state_q   <= ST_IDLE;
      clk_sel_q <= fc_lcc_svc_pkg::CLK_1000;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (clk_cmd_stb_i) begin
            state_q <= ST_REQ;
          end
        end
        // Hold the bypass request until the acknowledge is seen
        ST_REQ: begin
          if (clk_byp_ack_i) begin
            state_q   <= ST_SWITCH;
            clk_sel_q <= pend_sel_q;
          end
        end
        ST_SWITCH: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Selection waiting for the acknowledge
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && clk_cmd_stb_i) begin
      pend_sel_q <= clk_cmd_sel_i;
    end
  end

  assign clk_byp_req_o = (state_q == ST_REQ);
  assign clk_switch_o  = (state_q == ST_SWITCH);
  assign clk_sel_o     = clk_sel_q;

  a_switch_single: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    clk_switch_o |=> !clk_switch_o);

  a_sel_on_switch: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $changed(clk_sel_o) |-> clk_switch_o);

endmodule

// File: design/svc_override_ctrl.sv
module svc_override_ctrl (
  input  logic                         clk,
  input  logic                         cptra_rst_b,
  input  logic                         tb_service_cmd_valid_i,
  input  fc_lcc_svc_pkg::svc_cmd_u     tb_service_cmd_i,
  input  logic                         fips_zeroize_i,
  output logic                         zeroize_o,
  output logic                         escalate_o,
  output logic                         sva_disable_o,
  output logic                         clk_cmd_stb_o,
  output fc_lcc_svc_pkg::ext_clk_sel_e clk_cmd_sel_o,
  output logic                         rst_cmd_stb_o,
  output logic                         fault_cmd_stb_o,
  output fc_lcc_svc_pkg::fault_kind_e  fault_kind_o
);

  logic grp_ovr;
  logic grp_clk;
  logic grp_rf;

  logic zero_ovr_en_q;
  logic zero_ovr_val_q;
  logic escalate_q;
  logic sva_disable_q;

  // --------------------------------------------------
  // Group routing on the upper nibble
  // --------------------------------------------------
  assign grp_ovr = tb_service_cmd_valid_i &&
                   (tb_service_cmd_i.f.group == fc_lcc_svc_pkg::GRP_OVERRIDE);
  assign grp_clk = tb_service_cmd_valid_i &&
                   (tb_service_cmd_i.f.group == fc_lcc_svc_pkg::GRP_CLOCK);
  assign grp_rf  = tb_service_cmd_valid_i &&
                   (tb_service_cmd_i.f.group == fc_lcc_svc_pkg::GRP_RST_FAULT);

  // --------------------------------------------------
  // Override levels
  // --------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      zero_ovr_en_q  <= 1'b0;
      zero_ovr_val_q <= 1'b0;
      escalate_q     <= 1'b0;
      sva_disable_q  <= 1'b0;
    end else if (grp_ovr) begin
      case (tb_service_cmd_i.raw)
        fc_lcc_svc_pkg::CMD_ZEROIZE_ON: begin
          zero_ovr_en_q  <= 1'b1;
          zero_ovr_val_q <= 1'b1;
        end
        fc_lcc_svc_pkg::CMD_ZEROIZE_OFF: begin
          zero_ovr_en_q  <= 1'b1;
          zero_ovr_val_q <= 1'b0;
        end
        fc_lcc_svc_pkg::CMD_ZEROIZE_RELEASE: begin
          zero_ovr_en_q <= 1'b0;
        end
        // Escalation is sticky until the next subsystem reset
        fc_lcc_svc_pkg::CMD_TRIGGER_ESCALATION: begin
          escalate_q <= 1'b1;
        end
        fc_lcc_svc_pkg::CMD_DISABLE_SVA: begin
          sva_disable_q <= 1'b1;
        end
        fc_lcc_svc_pkg::CMD_ENABLE_SVA: begin
          sva_disable_q <= 1'b0;
        end
        default: begin
          // Unknown override codes leave the levels alone
        end
      endcase
    end
  end

  // Without an override the pin passes straight through
  assign zeroize_o     = zero_ovr_en_q ? zero_ovr_val_q : fips_zeroize_i;
  assign escalate_o    = escalate_q;
  assign sva_disable_o = sva_disable_q;

  // --------------------------------------------------
  // One-cycle strobes to the clock, reset and fault blocks
  // --------------------------------------------------
  always_comb begin
    clk_cmd_stb_o   = 1'b0;
    clk_cmd_sel_o   = fc_lcc_svc_pkg::CLK_1000;
    rst_cmd_stb_o   = 1'b0;
    fault_cmd_stb_o = 1'b0;
    fault_kind_o    = fc_lcc_svc_pkg::FAULT_CORRECTABLE;
    if (grp_clk) begin
      clk_cmd_stb_o = 1'b1;
      case (tb_service_cmd_i.raw)
        fc_lcc_svc_pkg::CMD_EXT_CLK_160:  clk_cmd_sel_o = fc_lcc_svc_pkg::CLK_160;
        fc_lcc_svc_pkg::CMD_EXT_CLK_400:  clk_cmd_sel_o = fc_lcc_svc_pkg::CLK_400;
        fc_lcc_svc_pkg::CMD_EXT_CLK_500:  clk_cmd_sel_o = fc_lcc_svc_pkg::CLK_500;
        fc_lcc_svc_pkg::CMD_EXT_CLK_1000: clk_cmd_sel_o = fc_lcc_svc_pkg::CLK_1000;
        default:                          clk_cmd_stb_o = 1'b0;
      endcase
    end
    if (grp_rf) begin
      case (tb_service_cmd_i.raw)
        fc_lcc_svc_pkg::CMD_FC_LCC_RESET: begin
          rst_cmd_stb_o = 1'b1;
        end
        fc_lcc_svc_pkg::CMD_CORRECTABLE_FAULT: begin
          fault_cmd_stb_o = 1'b1;
        end
        fc_lcc_svc_pkg::CMD_UNCORRECTABLE_FAULT: begin
          fault_cmd_stb_o = 1'b1;
          fault_kind_o    = fc_lcc_svc_pkg::FAULT_UNCORRECTABLE;
        end
        default: begin
        end
      endcase
    end
  end

  // The three downstream blocks never see work in the same cycle
  a_one_strobe: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $onehot0({clk_cmd_stb_o, rst_cmd_stb_o, fault_cmd_stb_o}));

endmodule

// File: design/svc_reset_timer.sv
module svc_reset_timer #(
  parameter int RESET_CYCLES = 10
) (
  input  logic clk,
  input  logic cptra_rst_b,
  input  logic rst_cmd_stb_i,
  output logic fc_lcc_rst_b_o
);

  localparam int CNT_W = $clog2(RESET_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             busy;

  assign busy = (cnt_q != '0);

  // --------------------------------------------------
  // Down-counter for the local reset pulse
  // --------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      cnt_q <= '0;
    end else if (busy) begin
      // A new request during the pulse does not stretch it
      cnt_q <= cnt_q - 1'b1;
    end else if (rst_cmd_stb_i) begin
      cnt_q <= CNT_W'(RESET_CYCLES);
    end
  end

  assign fc_lcc_rst_b_o = !busy;

  // Once the pulse starts it must end within RESET_CYCLES cycles
  a_pulse_len: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $fell(fc_lcc_rst_b_o) |-> ##[1:RESET_CYCLES] fc_lcc_rst_b_o);

endmodule

// File: files.f
design/fc_lcc_svc_pkg.sv
design/svc_override_ctrl.sv
design/svc_clk_switch_fsm.sv
design/svc_reset_timer.sv
design/otp_mem.sv
design/otp_fault_inject.sv
design/fc_lcc_svc_top.sv
tests/tb_fc_lcc_svc.sv

// File: tests/tb_fc_lcc_svc.sv
module tb_fc_lcc_svc;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int NUM_WORDS      = 64;
  localparam int PART_OFFSET [4] = '{0, 12, 24, 40};
  localparam int PART_DIGEST [4] = '{10, 22, 38, 62};
  localparam logic [7:0] CLK_CMDS [4] = '{8'h10, 8'h11, 8'h12, 8'h13};

  logic                         clk;
  logic                         cptra_rst_b;
  logic                         cmd_valid;
  logic [7:0]                   cmd;
  logic                         fips_zeroize;
  logic                         clk_byp_ack;
  logic                         otp_wr_en;
  logic [5:0]                   otp_addr;
  logic [15:0]                  otp_wdata;
  logic [5:0]                   otp_rd_addr;
  logic                         zeroize;
  logic                         escalate;
  logic                         sva_disable;
  logic                         clk_byp_req;
  logic                         clk_switch;
  fc_lcc_svc_pkg::ext_clk_sel_e clk_sel;
  logic                         fc_lcc_rst_b;
  logic [15:0]                  otp_rdata;

  logic [31:0] rng_state;
  logic [15:0] image [NUM_WORDS];
  int          cycles;

  fc_lcc_svc_top #(
    .RESET_CYCLES (RESET_CYCLES)
  ) i_dut (
    .clk                    (clk),
    .cptra_rst_b            (cptra_rst_b),
    .tb_service_cmd_valid_i (cmd_valid),
    .tb_service_cmd_i       (cmd),
    .fips_zeroize_i         (fips_zeroize),
    .clk_byp_ack_i          (clk_byp_ack),
    .otp_wr_en_i            (otp_wr_en),
    .otp_addr_i             (otp_addr),
    .otp_wdata_i            (otp_wdata),
    .otp_rd_addr_i          (otp_rd_addr),
    .zeroize_o              (zeroize),
    .escalate_o             (escalate),
    .sva_disable_o          (sva_disable),
    .clk_byp_req_o          (clk_byp_req),
    .clk_switch_o           (clk_switch),
    .clk_sel_o              (clk_sel),
    .fc_lcc_rst_b_o         (fc_lcc_rst_b),
    .otp_rdata_o            (otp_rdata)
  );

  always #50 clk = ~clk;

  // Watchdog on the total run length
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish");
      $display("Testbench failed");
      $fatal(1, "run stopped by watchdog");
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s (got 0x%0h, expected 0x%0h)",
               $time, msg, actual, expected);
      $display("Testbench failed");
      $fatal(1, "value check failed");
    end
  endtask

  // Inputs change 5 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic apply_reset();
    cptra_rst_b = 1'b0;
    repeat (4) next_cycle();
    cptra_rst_b = 1'b1;
    next_cycle();
  endtask

  task automatic send_cmd(input logic [7:0] code);
    cmd_valid = 1'b1;
    cmd       = code;
    next_cycle();
    cmd_valid = 1'b0;
    cmd       = '0;
  endtask

  task automatic otp_write(input logic [5:0] addr, input logic [15:0] data);
    otp_wr_en = 1'b1;
    otp_addr  = addr;
    otp_wdata = data;
    next_cycle();
    otp_wr_en = 1'b0;
  endtask

  task automatic otp_read(input logic [5:0] addr, output logic [15:0] data);
    otp_rd_addr = addr;
    next_cycle();
    data = otp_rdata;
  endtask

  // Even partitions get a nonzero digest and count as locked
  task automatic build_image();
    for (int a = 0; a < NUM_WORDS; a++) begin
      image[6'(a)] = 16'(next_random());
    end
    for (int p = 0; p < 4; p++) begin
      image[6'(PART_DIGEST[p])] = (p % 2 == 0) ? (16'(next_random()) | 16'h0001) : 16'h0000;
    end
  endtask

  task automatic load_image();
    for (int a = 0; a < NUM_WORDS; a++) begin
      otp_write(6'(a), image[6'(a)]);
    end
  endtask

  // Expected read data once a fault of the given kind is active
  function automatic logic [15:0] faulted_word(input int addr, input bit uncorrectable);
    logic [15:0] w;
    w = image[6'(addr)];
    for (int p = 0; p < 4; p++) begin
      if (addr == PART_OFFSET[p] && image[6'(PART_DIGEST[p])] != 16'h0000) begin
        w = uncorrectable ? ~image[6'(addr)] : (image[6'(addr)] ^ 16'h0001);
      end
    end
    return w;
  endfunction

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic reset_defaults();
    check(32'(clk_byp_req), 0, "clk_byp_req_o after reset");
    check(32'(clk_switch), 0, "clk_switch_o after reset");
    check(32'(escalate), 0, "escalate_o after reset");
    check(32'(sva_disable), 0, "sva_disable_o after reset");
    check(32'(fc_lcc_rst_b), 1, "fc_lcc_rst_b_o after reset");
    check(32'(clk_sel), 32'(fc_lcc_svc_pkg::CLK_1000), "clk_sel_o after reset");
    fips_zeroize = 1'b1;
    #1;
    check(32'(zeroize), 1, "zeroize_o follows input high");
    fips_zeroize = 1'b0;
    #1;
    check(32'(zeroize), 0, "zeroize_o follows input low");
  endtask

  task automatic zeroize_overrides();
    fips_zeroize = 1'b0;
    send_cmd(fc_lcc_svc_pkg::CMD_ZEROIZE_ON);
    check(32'(zeroize), 1, "zeroize forced on");
    fips_zeroize = 1'b1;
    send_cmd(fc_lcc_svc_pkg::CMD_ZEROIZE_OFF);
    check(32'(zeroize), 0, "zeroize forced off");
    send_cmd(fc_lcc_svc_pkg::CMD_ZEROIZE_RELEASE);
    check(32'(zeroize), 1, "zeroize released, input high");
    fips_zeroize = 1'b0;
    #1;
    check(32'(zeroize), 0, "zeroize released, input low");
    send_cmd(fc_lcc_svc_pkg::CMD_TRIGGER_ESCALATION);
    check(32'(escalate), 1, "escalation set");
    send_cmd(fc_lcc_svc_pkg::CMD_DISABLE_SVA);
    check(32'(sva_disable), 1, "assertions disabled");
    send_cmd(fc_lcc_svc_pkg::CMD_ENABLE_SVA);
    check(32'(sva_disable), 0, "assertions enabled");
    send_cmd(8'h3f);
    check(32'(escalate), 1, "escalation stays set");
  endtask

  task automatic clock_switch();
    int delay;
    for (int k = 0; k < 4; k++) begin
      delay = 1 + int'(next_random() % 8);
      check(32'(clk_byp_req), 0, "no request before clock command");
      send_cmd(CLK_CMDS[k]);
      check(32'(clk_byp_req), 1, "request after clock command");
      // A second command while pending must be dropped
      send_cmd(CLK_CMDS[(k + 1) % 4]);
      check(32'(clk_byp_req), 1, "request held while pending");
      for (int i = 1; i < delay; i++) begin
        next_cycle();
        check(32'(clk_byp_req), 1, "request held before acknowledge");
        check(32'(clk_switch), 0, "no switch before acknowledge");
      end
      clk_byp_ack = 1'b1;
      next_cycle();
      clk_byp_ack = 1'b0;
      check(32'(clk_byp_req), 0, "request drops at acknowledge");
      check(32'(clk_switch), 1, "switch pulse at acknowledge");
      check(32'(clk_sel), k, "selected clock code");
      next_cycle();
      check(32'(clk_switch), 0, "switch pulse lasts one cycle");
      check(32'(clk_sel), k, "selected clock code holds");
    end
  endtask

  task automatic local_reset_pulse();
    send_cmd(fc_lcc_svc_pkg::CMD_FC_LCC_RESET);
    for (int i = 0; i < RESET_CYCLES; i++) begin
      check(32'(fc_lcc_rst_b), 0, "local reset low during pulse");
      if (i == RESET_CYCLES / 2) begin
        cmd_valid = 1'b1;
        cmd       = fc_lcc_svc_pkg::CMD_FC_LCC_RESET;
      end
      next_cycle();
      cmd_valid = 1'b0;
    end
    check(32'(fc_lcc_rst_b), 1, "local reset released after pulse");
    next_cycle();
    check(32'(fc_lcc_rst_b), 1, "repeat command did not restart pulse");
  endtask

  task automatic correctable_fault();
    logic [15:0] data;
    apply_reset();
    build_image();
    load_image();
    otp_read(6'(PART_OFFSET[0]), data);
    check(32'(data), 32'(image[6'(PART_OFFSET[0])]), "raw read before fault");
    send_cmd(fc_lcc_svc_pkg::CMD_CORRECTABLE_FAULT);
    for (int a = 0; a < NUM_WORDS; a++) begin
      otp_read(6'(a), data);
      check(32'(data), 32'(faulted_word(a, 1'b0)),
            $sformatf("correctable fault read of word %0d", a));
    end
    // Later fault commands leave the captured words alone
    send_cmd(fc_lcc_svc_pkg::CMD_UNCORRECTABLE_FAULT);
    for (int p = 0; p < 4; p++) begin
      otp_read(6'(PART_OFFSET[p]), data);
      check(32'(data), 32'(faulted_word(PART_OFFSET[p], 1'b0)),
            $sformatf("fault kept after second command, partition %0d", p));
    end
  endtask

  task automatic uncorrectable_fault();
    logic [15:0] data;
    apply_reset();
    load_image();
    send_cmd(fc_lcc_svc_pkg::CMD_UNCORRECTABLE_FAULT);
    for (int a = 0; a < NUM_WORDS; a++) begin
      otp_read(6'(a), data);
      check(32'(data), 32'(faulted_word(a, 1'b1)),
            $sformatf("uncorrectable fault read of word %0d", a));
    end
  endtask

  initial begin
    clk          = 1'b0;
    cptra_rst_b  = 1'b0;
    cmd_valid    = 1'b0;
    cmd          = '0;
    fips_zeroize = 1'b0;
    clk_byp_ack  = 1'b0;
    otp_wr_en    = 1'b0;
    otp_addr     = '0;
    otp_wdata    = '0;
    otp_rd_addr  = '0;
    rng_state    = 32'd26639;
    cycles       = 0;
    apply_reset();
    reset_defaults();
    zeroize_overrides();
    clock_switch();
    local_reset_pulse();
    correctable_fault();
    uncorrectable_fault();
    $display("Testbench passed");
    $finish;
  end

endmodule
